// ==== flist.f ====
+incdir+sim
hw/isa_pkg.sv
hw/mem_pkg.sv
hw/access_planner.sv
hw/word_ram.sv
hw/load_formatter.sv
hw/mem_access_top.sv
sim/tb_mem_access.sv

// ==== Makefile ====
# Verilator build and run of the memory access testbench
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mem_access
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then \
	  echo "simulation reported a failure"; exit 1; \
	fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_vectors.svh ====
// rows run in order and share memory state; expected rdata is 0 for stores and refused requests
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// op, funct3, byte address, store data, expected rdata, expected err
typedef struct packed {
  mem_op_t     op;
  logic [2:0]  funct3;
  logic [63:0] addr;
  logic [63:0] wdata;
  logic [63:0] exp_rdata;
  logic        exp_err;
} vector_t;

localparam int n_vectors = 40;

localparam vector_t vectors [n_vectors] = '{
  // aligned double, then narrower loads of the same word
  '{op_store, funct3_sd,  64'h8000_0000, 64'h1122_3344_5566_7788, 64'h0, 1'b0},
  '{op_load,  funct3_ld,  64'h8000_0000, 64'h0, 64'h1122_3344_5566_7788, 1'b0},
  '{op_load,  funct3_lw,  64'h8000_0004, 64'h0, 64'h0000_0000_1122_3344, 1'b0},
  '{op_load,  funct3_lh,  64'h8000_0002, 64'h0, 64'h0000_0000_0000_5566, 1'b0},
  '{op_load,  funct3_lb,  64'h8000_0007, 64'h0, 64'h0000_0000_0000_0011, 1'b0},
  // negative bytes, signed against unsigned
  '{op_store, funct3_sd,  64'h8000_0008, 64'hf0e1_d2c3_b4a5_9687, 64'h0, 1'b0},
  '{op_load,  funct3_lb,  64'h8000_0008, 64'h0, 64'hffff_ffff_ffff_ff87, 1'b0},
  '{op_load,  funct3_lbu, 64'h8000_0008, 64'h0, 64'h0000_0000_0000_0087, 1'b0},
  '{op_load,  funct3_lh,  64'h8000_000a, 64'h0, 64'hffff_ffff_ffff_b4a5, 1'b0},
  '{op_load,  funct3_lhu, 64'h8000_000a, 64'h0, 64'h0000_0000_0000_b4a5, 1'b0},
  '{op_load,  funct3_lw,  64'h8000_000c, 64'h0, 64'hffff_ffff_f0e1_d2c3, 1'b0},
  '{op_load,  funct3_lwu, 64'h8000_000c, 64'h0, 64'h0000_0000_f0e1_d2c3, 1'b0},
  // aligned narrow stores
  '{op_store, funct3_sw,  64'h8000_0010, 64'hdead_beef_0bad_f00d, 64'h0, 1'b0},
  '{op_load,  funct3_lw,  64'h8000_0010, 64'h0, 64'h0000_0000_0bad_f00d, 1'b0},
  '{op_store, funct3_sh,  64'h8000_0014, 64'h0000_0000_1234_8001, 64'h0, 1'b0},
  '{op_load,  funct3_lh,  64'h8000_0014, 64'h0, 64'hffff_ffff_ffff_8001, 1'b0},
  '{op_store, funct3_sb,  64'h8000_0016, 64'h0000_0000_0000_ab7f, 64'h0, 1'b0},
  '{op_load,  funct3_lb,  64'h8000_0016, 64'h0, 64'h0000_0000_0000_007f, 1'b0},
  // accesses split over two words
  '{op_store, funct3_sd,  64'h8000_001d, 64'h0102_0304_0506_0708, 64'h0, 1'b0},
  '{op_load,  funct3_ld,  64'h8000_001d, 64'h0, 64'h0102_0304_0506_0708, 1'b0},
  '{op_store, funct3_sw,  64'h8000_002e, 64'h0000_0000_cafe_babe, 64'h0, 1'b0},
  '{op_load,  funct3_lw,  64'h8000_002e, 64'h0, 64'hffff_ffff_cafe_babe, 1'b0},
  '{op_load,  funct3_lwu, 64'h8000_002e, 64'h0, 64'h0000_0000_cafe_babe, 1'b0},
  '{op_store, funct3_sh,  64'h8000_003f, 64'h0000_0000_0000_9a5c, 64'h0, 1'b0},
  '{op_load,  funct3_lh,  64'h8000_003f, 64'h0, 64'hffff_ffff_ffff_9a5c, 1'b0},
  '{op_load,  funct3_lhu, 64'h8000_003f, 64'h0, 64'h0000_0000_0000_9a5c, 1'b0},
  // narrow stores leave their neighbors alone
  '{op_store, funct3_sb,  64'h8000_0003, 64'h0000_0000_0000_00ee, 64'h0, 1'b0},
  '{op_load,  funct3_ld,  64'h8000_0000, 64'h0, 64'h1122_3344_ee66_7788, 1'b0},
  '{op_store, funct3_sd,  64'h8000_0048, 64'h8877_6655_4433_2211, 64'h0, 1'b0},
  '{op_store, funct3_sd,  64'h8000_0050, 64'hffee_ddcc_bbaa_9988, 64'h0, 1'b0},
  '{op_store, funct3_sw,  64'h8000_004e, 64'h0000_0000_1357_9bdf, 64'h0, 1'b0},
  '{op_load,  funct3_ld,  64'h8000_0048, 64'h0, 64'h9bdf_6655_4433_2211, 1'b0},
  '{op_load,  funct3_ld,  64'h8000_0050, 64'h0, 64'hffee_ddcc_bbaa_1357, 1'b0},
  // below the base, past the end, second word past the end
  '{op_load,  funct3_ld,  64'h7fff_fff8, 64'h0, 64'h0, 1'b1},
  '{op_load,  funct3_lw,  64'h8000_1000, 64'h0, 64'h0, 1'b1},
  '{op_store, funct3_sd,  64'h8000_0ff8, 64'h0123_4567_89ab_cdef, 64'h0, 1'b0},
  '{op_store, funct3_sd,  64'h8000_0ffc, 64'hffff_ffff_ffff_ffff, 64'h0, 1'b1},
  '{op_load,  funct3_ld,  64'h8000_0ff8, 64'h0, 64'h0123_4567_89ab_cdef, 1'b0},
  '{op_load,  funct3_lh,  64'h8000_0fff, 64'h0, 64'h0, 1'b1},
  '{op_load,  funct3_lb,  64'h8000_0fff, 64'h0, 64'h0000_0000_0000_0001, 1'b0}
};

`endif

// ==== sim/tb_mem_access.sv ====
// each response checked one cycle after its request; random accesses stay in a pre-filled window
`timescale 1ns/1ps

module tb_mem_access
  import isa_pkg::*;
  import mem_pkg::*;
();

  `include "tb_vectors.svh"

  localparam int          random_count = 400;
  localparam int          window_words = 8;
  localparam int          window_bytes = window_words * 8;
  localparam logic [63:0] window_base  = mem_base + 64'h100;
  localparam int          cycle_limit  = 2 * n_vectors + window_words + random_count + 50;

  logic     clk;
  logic     reset;
  logic     req_valid;
  mem_req_t req;
  logic     rsp_valid;
  mem_rsp_t rsp;

  // response due in the current cycle
  logic        exp_valid;
  logic [63:0] exp_rdata;
  logic        exp_err;
  int          exp_tag;

  logic [7:0] shadow [window_bytes];
  integer     seed;
  int         cycles = 0;

  mem_access_top UUT (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      stop_on_failure();
    end
  end

  task automatic stop_on_failure();
    $display("TESTS FAILED");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic check_response();
    assert (rsp_valid == exp_valid) else begin
      $display("error: %0d ns, request %0d, rsp_valid is %0b, expected %0b",
               $time, exp_tag, rsp_valid, exp_valid);
      stop_on_failure();
    end
    if (exp_valid) begin
      assert (rsp.err == exp_err) else begin
        $display("error: %0d ns, request %0d, err is %0b, expected %0b",
                 $time, exp_tag, rsp.err, exp_err);
        stop_on_failure();
      end
      assert (rsp.rdata == exp_rdata) else begin
        $display("error: %0d ns, request %0d, rdata is %h, expected %h",
                 $time, exp_tag, rsp.rdata, exp_rdata);
        stop_on_failure();
      end
    end
  endtask

  // drive one request, then check the one issued a cycle earlier
  task automatic issue_request(input mem_op_t op, input logic [2:0] f3,
                               input logic [63:0] addr, input logic [63:0] wdata,
                               input logic [63:0] rdata_exp, input logic err_exp,
                               input int tag);
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= '{op, f3, addr, wdata};
    @(negedge clk);
    check_response();
    exp_valid = 1'b1;
    exp_rdata = rdata_exp;
    exp_err   = err_exp;
    exp_tag   = tag;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    req_valid <= 1'b0;
    @(negedge clk);
    check_response();
    exp_valid = 1'b0;
  endtask

  function automatic void store_shadow(input int off, input logic [2:0] f3,
                                       input logic [63:0] data);
    int size;
    size = 1 << f3[1:0];
    for (int b = 0; b < size; b++) begin
      shadow[off + b] = data[b*8 +: 8];
    end
  endfunction

  // little-endian bytes from the shadow, then sign or zero extension
  function automatic logic [63:0] expected_load(input int off, input logic [2:0] f3);
    logic [63:0] raw;
    logic [63:0] val;
    int          size;
    raw  = '0;
    size = 1 << f3[1:0];
    for (int b = 7; b >= 0; b--) begin
      if (b < size) begin
        raw = {raw[55:0], shadow[off + b]};
      end else begin
        raw = {raw[55:0], 8'h00};
      end
    end
    case (f3)
      funct3_lb:  val = {{56{raw[7]}}, raw[7:0]};
      funct3_lh:  val = {{48{raw[15]}}, raw[15:0]};
      funct3_lw:  val = {{32{raw[31]}}, raw[31:0]};
      funct3_lbu: val = {56'h0, raw[7:0]};
      funct3_lhu: val = {48'h0, raw[15:0]};
      funct3_lwu: val = {32'h0, raw[31:0]};
      default:    val = raw;
    endcase
    return val;
  endfunction

  initial begin
    mem_op_t     op;
    logic [2:0]  f3;
    logic [2:0]  last_f3;
    logic [63:0] data;
    logic [63:0] rdata_exp;
    logic        last_store;
    int          size;
    int          off;
    int          last_off;

    seed       = 40113;
    reset      = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    exp_valid  = 1'b0;
    exp_rdata  = '0;
    exp_err    = 1'b0;
    exp_tag    = 0;
    last_store = 1'b0;
    last_f3    = '0;
    last_off   = 0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    for (int i = 0; i < n_vectors; i++) begin
      issue_request(vectors[i].op, vectors[i].funct3, vectors[i].addr, vectors[i].wdata,
                    vectors[i].exp_rdata, vectors[i].exp_err, i);
    end
    idle_cycle();

    // every window byte gets a known value first
    for (int w = 0; w < window_words; w++) begin
      data = {$random(seed), $random(seed)};
      store_shadow(w * 8, funct3_sd, data);
      issue_request(op_store, funct3_sd, window_base + 64'(w * 8), data, 64'h0, 1'b0,
                    n_vectors + w);
    end

    for (int n = 0; n < random_count; n++) begin
      if (last_store && ($random(seed) & 1)) begin
        // read back what was just written
        op = op_load;
        f3 = last_f3;
        off = last_off;
      end else begin
        op = ($random(seed) & 1) ? op_store : op_load;
        if (op == op_store) begin
          f3 = 3'($unsigned($random(seed)) % 4);
        end else begin
          f3 = 3'($unsigned($random(seed)) % 7);
        end
        size = 1 << f3[1:0];
        off = int'($unsigned($random(seed)) % (window_bytes - size + 1));
      end
      data = {$random(seed), $random(seed)};
      if (op == op_store) begin
        store_shadow(off, f3, data);
        rdata_exp = 64'h0;
      end else begin
        rdata_exp = expected_load(off, f3);
      end
      issue_request(op, f3, window_base + 64'(off), data, rdata_exp, 1'b0,
                    n_vectors + window_words + n);
      last_store = (op == op_store);
      last_f3    = f3;
      last_off   = off;
    end
    idle_cycle();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== hw/mem_access_top.sv ====
// one request per cycle with no back-pressure; every request gets a response in the next cycle
`timescale 1ns/1ps

module mem_access_top
  import isa_pkg::*;
  import mem_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     req_valid,
  input  mem_req_t req,
  output logic     rsp_valid,
  output mem_rsp_t rsp
);

  ram_port_t       port_lo;
  ram_port_t       port_hi;
  load_info_t      info;
  logic            info_valid;
  logic [xlen-1:0] rdata_lo;
  logic [xlen-1:0] rdata_hi;

  // address check and split into word ports
  access_planner u_planner (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req),
    .port_lo    (port_lo),
    .port_hi    (port_hi),
    .info       (info),
    .info_valid (info_valid)
  );

  // word storage, written and read at the same edge
  word_ram u_ram (
    .clk      (clk),
    .port_lo  (port_lo),
    .port_hi  (port_hi),
    .rdata_lo (rdata_lo),
    .rdata_hi (rdata_hi)
  );

  // merge, extend and respond
  load_formatter u_formatter (
    .clk        (clk),
    .reset      (reset),
    .info       (info),
    .info_valid (info_valid),
    .rdata_lo   (rdata_lo),
    .rdata_hi   (rdata_hi),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp)
  );

endmodule

// ==== hw/load_formatter.sv ====
// response comes out one cycle after the request; stores and refused requests return rdata 0
`timescale 1ns/1ps

module load_formatter
  import isa_pkg::*;
  import mem_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  load_info_t      info,
  input  logic            info_valid,
  input  logic [xlen-1:0] rdata_lo,
  input  logic [xlen-1:0] rdata_hi,
  output logic            rsp_valid,
  output mem_rsp_t        rsp
);

  logic              valid_q;
  logic [5:0]        bit_off;
  logic [xlen-1:0]   hi_sel;
  logic [2*xlen-1:0] pair;
  logic [xlen-1:0]   merged;
  logic [xlen-1:0]   ext;

  // strobe follows the RAM read by one edge
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= info_valid;
    end
  end

  assign rsp_valid = valid_q;

  // high word port keeps stale data when unused
  assign hi_sel  = info.two_words ? rdata_hi : '0;
  assign bit_off = {info.byte_off, 3'b000};
  assign pair    = {hi_sel, rdata_lo} >> bit_off;
  assign merged  = pair[xlen-1:0];

  // pick the width, then sign or zero extend
  always_comb begin
    case (info.funct3)
      funct3_lb:  ext = {{56{merged[7]}}, merged[7:0]};
      funct3_lh:  ext = {{48{merged[15]}}, merged[15:0]};
      funct3_lw:  ext = {{32{merged[31]}}, merged[31:0]};
      funct3_ld:  ext = merged;
      funct3_lbu: ext = {56'h0, merged[7:0]};
      funct3_lhu: ext = {48'h0, merged[15:0]};
      funct3_lwu: ext = {32'h0, merged[31:0]};
      default:    ext = '0;
    endcase
  end

  always_comb begin
    rsp.err   = info.err;
    rsp.rdata = (info.is_load && !info.err) ? ext : '0;
  end

endmodule

// ==== hw/word_ram.sv ====
// two ports must never hit the same word in one cycle; contents come up undefined after reset
`timescale 1ns/1ps

module word_ram
  import isa_pkg::*;
  import mem_pkg::*;
(
  input  logic            clk,
  input  ram_port_t       port_lo,
  input  ram_port_t       port_hi,
  output logic [xlen-1:0] rdata_lo,
  output logic [xlen-1:0] rdata_hi
);

  logic [xlen-1:0] mem [ram_words];
  ram_port_t       ports [2];
  logic [xlen-1:0] rd_q [2];

  assign ports[0] = port_lo;
  assign ports[1] = port_hi;

  // both ports handled by one process so the array has a single writer
  always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      if (ports[p].en) begin
        if (ports[p].we) begin
          // only the selected byte lanes change
          for (int b = 0; b < xlen_bytes; b++) begin
            if (ports[p].wmask[b]) begin
              mem[ports[p].idx][b*8 +: 8] <= ports[p].wdata[b*8 +: 8];
            end
          end
        end else begin
          rd_q[p] <= mem[ports[p].idx];
        end
      end
    end
  end

  // read data holds until the port reads again
  assign rdata_lo = rd_q[0];
  assign rdata_hi = rd_q[1];

endmodule

// ==== hw/access_planner.sv ====
// combinational split into word ports; info is registered so it lines up with the RAM read data
`timescale 1ns/1ps

module access_planner
  import isa_pkg::*;
  import mem_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       req_valid,
  input  mem_req_t   req,
  output ram_port_t  port_lo,
  output ram_port_t  port_hi,
  output load_info_t info,
  output logic       info_valid
);

  logic [63:0]           addr_rel;
  logic [60:0]           word_lo;
  logic [2:0]            byte_off;
  logic [5:0]            bit_off;
  logic [3:0]            nbytes;
  logic [3:0]            end_byte;
  logic                  two_words;
  logic                  is_store;
  logic                  legal_code;
  logic                  in_range;
  logic                  err;
  logic                  go;
  logic [word_idx_w-1:0] idx_lo;
  logic [15:0]           mask_wide;
  logic [2*xlen-1:0]     data_wide;
  load_info_t            info_q;

  // offset from the memory base, in bytes and in words
  assign addr_rel = req.addr - mem_base;
  assign word_lo  = addr_rel[63:3];
  assign byte_off = addr_rel[2:0];
  assign bit_off  = {byte_off, 3'b000};

  // a second word is needed when the access runs past byte 7
  assign nbytes    = access_bytes(req.funct3);
  assign end_byte  = {1'b0, byte_off} + nbytes;
  assign two_words = end_byte > 4'(xlen_bytes);

  assign is_store = (req.op == op_store);

  always_comb begin
    if (is_store) begin
      legal_code = req.funct3 inside {funct3_sb, funct3_sh, funct3_sw, funct3_sd};
    end else begin
      legal_code = req.funct3 inside {funct3_lb, funct3_lh, funct3_lw, funct3_ld,
                                      funct3_lbu, funct3_lhu, funct3_lwu};
    end
  end

  // addresses below the base wrap to a huge word index and fail here too
  always_comb begin
    in_range = word_lo < 61'(ram_words);
    if (two_words && word_lo == 61'(ram_words - 1)) begin
      in_range = 1'b0;
    end
  end

  assign err    = req_valid & ~(legal_code & in_range);
  assign go     = req_valid & ~err;
  assign idx_lo = word_lo[word_idx_w-1:0];

  // lanes and data shifted into place, high half spills into the next word
  assign mask_wide = {8'h00, lane_mask(req.funct3)} << byte_off;
  assign data_wide = {{xlen{1'b0}}, req.wdata} << bit_off;

  always_comb begin
    port_lo.en    = go;
    port_lo.we    = go & is_store;
    port_lo.idx   = idx_lo;
    port_lo.wdata = data_wide[xlen-1:0];
    port_lo.wmask = is_store ? mask_wide[7:0] : 8'h00;

    port_hi.en    = go & two_words;
    port_hi.we    = go & two_words & is_store;
    port_hi.idx   = idx_lo + 1'b1;
    port_hi.wdata = data_wide[2*xlen-1:xlen];
    port_hi.wmask = (is_store && two_words) ? mask_wide[15:8] : 8'h00;
  end

  // held for one cycle, next to the RAM read data
  always_ff @(posedge clk) begin
    if (reset) begin
      info_q <= '0;
    end else begin
      info_q.is_load   <= req_valid & ~is_store;
      info_q.err       <= err;
      info_q.byte_off  <= byte_off;
      info_q.two_words <= two_words;
      info_q.funct3    <= req.funct3;
    end
  end

  assign info = info_q;

  // the formatter registers the strobe at the same edge
  assign info_valid = req_valid;

endmodule

// ==== hw/mem_pkg.sv ====
// memory of 512 words at 0x8000_0000; no back-pressure, so structs carry no ready fields
package mem_pkg;

  import isa_pkg::*;

  // byte address of word 0
  localparam logic [63:0] mem_base = 64'h0000_0000_8000_0000;

  // geometry
  localparam int ram_words  = 512;
  localparam int word_idx_w = $clog2(ram_words);

  // direction of a request
  typedef enum logic {
    op_load  = 1'b0,
    op_store = 1'b1
  } mem_op_t;

  // request from the core, valid with req_valid
  typedef struct packed {
    mem_op_t         op;
    logic [2:0]      funct3;
    logic [63:0]     addr;
    logic [xlen-1:0] wdata;
  } mem_req_t;

  // response, one cycle after its request
  typedef struct packed {
    logic [xlen-1:0] rdata;
    logic            err;
  } mem_rsp_t;

  // one operation on a single RAM word port
  typedef struct packed {
    logic                  en;
    logic                  we;
    logic [word_idx_w-1:0] idx;
    logic [xlen-1:0]       wdata;
    logic [xlen_bytes-1:0] wmask;
  } ram_port_t;

  // what the formatter keeps from a request to finish it
  typedef struct packed {
    logic       is_load;
    logic       err;
    logic [2:0] byte_off;
    logic       two_words;
    logic [2:0] funct3;
  } load_info_t;

endpackage

// ==== hw/isa_pkg.sv ====
// RV64 load/store width codes; funct3[1:0] is log2 of the access size, funct3[2] marks unsigned
package isa_pkg;

  // data path width
  localparam int xlen       = 64;
  localparam int xlen_bytes = xlen / 8;

  // load width codes
  localparam logic [2:0] funct3_lb  = 3'b000;
  localparam logic [2:0] funct3_lh  = 3'b001;
  localparam logic [2:0] funct3_lw  = 3'b010;
  localparam logic [2:0] funct3_ld  = 3'b011;
  localparam logic [2:0] funct3_lbu = 3'b100;
  localparam logic [2:0] funct3_lhu = 3'b101;
  localparam logic [2:0] funct3_lwu = 3'b110;

  // store width codes, never unsigned
  localparam logic [2:0] funct3_sb = 3'b000;
  localparam logic [2:0] funct3_sh = 3'b001;
  localparam logic [2:0] funct3_sw = 3'b010;
  localparam logic [2:0] funct3_sd = 3'b011;

  // bytes touched by an access: 1, 2, 4 or 8
  function automatic logic [3:0] access_bytes(input logic [2:0] funct3);
    logic [3:0] n;
    case (funct3[1:0])
      2'b00:   n = 4'd1;
      2'b01:   n = 4'd2;
      2'b10:   n = 4'd4;
      default: n = 4'd8;
    endcase
    return n;
  endfunction

  // byte lanes of an access before it is shifted by the offset
  function automatic logic [7:0] lane_mask(input logic [2:0] funct3);
    logic [7:0] m;
    case (funct3[1:0])
      2'b00:   m = 8'h01;
      2'b01:   m = 8'h03;
      2'b10:   m = 8'h0f;
      default: m = 8'hff;
    endcase
    return m;
  endfunction

endpackage
